//--- galois_lfsr.f
verilog/lfsr_pkg.sv
verilog/lfsr_seq_ctrl.sv
verilog/lfsr_shift_reg.sv
verilog/galois_lfsr.sv
test/galois_lfsr_checker.sv
test/galois_lfsr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Galois LFSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module galois_lfsr_tb \
    -f galois_lfsr.f -o galois_lfsr_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/galois_lfsr_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

//--- test/galois_lfsr_tb.sv
module galois_lfsr_tb;

    localparam int          WIDTH        = 8;
    localparam logic [7:0]  TAPS         = 8'h70;
    localparam int          PERIOD       = 255;
    localparam int          HALF_CYCLE   = 50;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          DONE_TIMEOUT = 300;
    localparam logic [31:0] PRNG_SEED    = 32'h1d32;
    localparam logic [31:0] PRNG_POLY    = 32'h80200003;

    logic             clk = 1'b0;
    logic             rst;
    logic             enable;
    logic             load_evt;
    logic [WIDTH-1:0] seed_data;
    logic             lfsr_vld;
    logic             lfsr_done;
    logic [WIDTH-1:0] lfsr_data;

    logic [31:0]      prng_state = PRNG_SEED;
    logic [WIDTH-1:0] model_state;
    logic [WIDTH-1:0] model_seed;
    logic             model_loaded;
    logic             model_vld;
    int               mismatch_count = 0;
    int               timeout_count  = 0;

    galois_lfsr #(
        .WIDTH(WIDTH)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .load_evt  (load_evt),
        .seed_data (seed_data),
        .lfsr_vld  (lfsr_vld),
        .lfsr_done (lfsr_done),
        .lfsr_data (lfsr_data)
    );

    always #HALF_CYCLE clk = ~clk;

    // ==========================================================
    // Reference model
    // ==========================================================
    function automatic logic [WIDTH-1:0] galois_next(input logic [WIDTH-1:0] s);
        logic [WIDTH-1:0] n;
        n = {s[WIDTH-2:0], s[WIDTH-1]};
        if (s[WIDTH-1]) begin
            n = n ^ TAPS;
        end
        return n;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            model_state  = WIDTH'(1);
            model_seed   = WIDTH'(1);
            model_loaded = 1'b0;
            model_vld    = 1'b0;
        end else begin
            if (enable) begin
                if (load_evt) begin
                    model_state  = seed_data;
                    model_seed   = seed_data;
                    model_loaded = 1'b1;
                end else if (!model_vld && !model_loaded) begin
                    model_state  = WIDTH'(1);
                    model_seed   = WIDTH'(1);
                    model_loaded = 1'b1;
                end else begin
                    model_state = galois_next(model_state);
                end
            end
            model_vld = enable;
        end
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (lfsr_data !== model_state) begin
            mismatch_count++;
            $display("Mismatch at %0t: lfsr_data %h, expected %h", $time, lfsr_data, model_state);
        end
        if (lfsr_vld !== model_vld) begin
            mismatch_count++;
            $display("Mismatch at %0t: lfsr_vld %b, expected %b", $time, lfsr_vld, model_vld);
        end
        if (lfsr_done !== (model_vld && model_state == model_seed)) begin
            mismatch_count++;
            $display("Mismatch at %0t: lfsr_done %b", $time, lfsr_done);
        end
    end

    // ==========================================================
    // Stimulus helpers
    // ==========================================================
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], prng_state[0]};
            if (prng_state[0]) begin
                prng_state = (prng_state >> 1) ^ PRNG_POLY;
            end else begin
                prng_state = prng_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic logic [WIDTH-1:0] random_seed();
        logic [31:0] r;
        r = take_bits(WIDTH);
        if (r[WIDTH-1:0] == '0) begin
            return 8'h5a;
        end
        return r[WIDTH-1:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_steps(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            enable   = 1'b1;
            load_evt = 1'b0;
            next_cycle();
        end
    endtask

    // Loads offered here must be ignored
    task automatic pause_cycles(input int n);
        logic [31:0] r;
        int          i;
        for (i = 0; i < n; i++) begin
            enable    = 1'b0;
            r         = take_bits(1);
            load_evt  = r[0];
            seed_data = random_seed();
            next_cycle();
        end
    endtask

    // Done is already high right after the load, so count to its next return
    task automatic measure_period(input logic [WIDTH-1:0] seed, input int pause_at);
        logic [31:0] r;
        int          steps;
        logic        seen_done;
        enable    = 1'b1;
        load_evt  = 1'b1;
        seed_data = seed;
        next_cycle();
        steps     = 0;
        seen_done = 1'b0;
        while (!seen_done && steps < DONE_TIMEOUT) begin
            if (steps == pause_at) begin
                r = take_bits(3);
                pause_cycles(1 + int'(r));
            end
            enable   = 1'b1;
            load_evt = 1'b0;
            next_cycle();
            steps++;
            seen_done = lfsr_done;
        end
        if (!seen_done) begin
            timeout_count++;
            $display("Timeout: lfsr_done did not return within %0d steps of seed %h",
                     DONE_TIMEOUT, seed);
        end else if (steps != PERIOD) begin
            mismatch_count++;
            $display("Mismatch at %0t: period %0d, expected %0d", $time, steps, PERIOD);
        end
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        logic [31:0] r;
        int          i;
        int          errors;
        rst       = 1'b1;
        enable    = 1'b0;
        load_evt  = 1'b0;
        seed_data = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        pause_cycles(3);
        // First enable takes the default seed
        run_steps(20);

        for (i = 0; i < 12; i++) begin
            r = take_bits(4);
            run_steps(1 + int'(r));
            r = take_bits(3);
            pause_cycles(1 + int'(r));
        end

        for (i = 0; i < 3; i++) begin
            measure_period(random_seed(), -1);
        end
        r = take_bits(7);
        measure_period(random_seed(), 20 + int'(r));

        pause_cycles(2);
        errors = mismatch_count + timeout_count + i_dut.i_checker.fail_count;
        $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, i_dut.i_checker.fail_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- test/galois_lfsr_checker.sv
module galois_lfsr_checker #(
    parameter int WIDTH = 8
) (
    input logic             clk,
    input logic             rst,
    input logic             enable,
    input logic             load_evt,
    input logic [WIDTH-1:0] seed_data,
    input logic             lfsr_vld,
    input logic             lfsr_done,
    input logic [WIDTH-1:0] lfsr_data
);

    int               fail_count = 0;
    logic             seen_load;
    logic [WIDTH-1:0] seed_ref;

    // Seed that one full period has to come back to
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_load <= 1'b0;
            seed_ref  <= WIDTH'(1);
        end else if (enable && load_evt) begin
            seen_load <= 1'b1;
            seed_ref  <= seed_data;
        end else if (enable && !lfsr_vld && !seen_load) begin
            seen_load <= 1'b1;
            seed_ref  <= WIDTH'(1);
        end
    end

    // ==========================================================
    // Properties
    // ==========================================================
    reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !lfsr_vld && !lfsr_done && lfsr_data == WIDTH'(1))
        else begin
            fail_count++;
            $error("Mismatch at %0t: outputs not at reset values while rst is high", $time);
        end

    first_enable_default: assert property (@(posedge clk) disable iff (rst)
        enable && !load_evt && !lfsr_vld && !seen_load |=> lfsr_data == WIDTH'(1))
        else begin
            fail_count++;
            $error("Mismatch at %0t: first enable did not leave the default seed", $time);
        end

    data_nonzero: assert property (@(posedge clk) disable iff (rst) lfsr_data != '0)
        else begin
            fail_count++;
            $error("Mismatch at %0t: register reached the all-zero state", $time);
        end

    vld_follows_enable: assert property (@(posedge clk) disable iff (rst)
        lfsr_vld == $past(enable))
        else begin
            fail_count++;
            $error("Mismatch at %0t: lfsr_vld is not enable delayed by one cycle", $time);
        end

    done_at_seed: assert property (@(posedge clk) disable iff (rst)
        lfsr_done |-> lfsr_vld && lfsr_data == seed_ref)
        else begin
            fail_count++;
            $error("Mismatch at %0t: lfsr_done high away from the seed", $time);
        end

    seed_gives_done: assert property (@(posedge clk) disable iff (rst)
        lfsr_vld && lfsr_data == seed_ref |-> lfsr_done)
        else begin
            fail_count++;
            $error("Mismatch at %0t: lfsr_done low at the seed", $time);
        end

    hold_when_paused: assert property (@(posedge clk) disable iff (rst)
        !enable |=> $stable(lfsr_data))
        else begin
            fail_count++;
            $error("Mismatch at %0t: lfsr_data moved while enable was low", $time);
        end

endmodule

bind galois_lfsr galois_lfsr_checker #(
    .WIDTH(WIDTH)
) i_checker (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .load_evt  (load_evt),
    .seed_data (seed_data),
    .lfsr_vld  (lfsr_vld),
    .lfsr_done (lfsr_done),
    .lfsr_data (lfsr_data)
);

//--- verilog/galois_lfsr.sv
module galois_lfsr #(
    parameter int WIDTH = lfsr_pkg::LFSR_DEFAULT_WIDTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  logic             load_evt,
    input  logic [WIDTH-1:0] seed_data,
    output logic             lfsr_vld,
    output logic             lfsr_done,
    output logic [WIDTH-1:0] lfsr_data
);

    lfsr_pkg::lfsr_op_e op;
    logic [WIDTH-1:0]   state;

    // Widths without a primitive polynomial stop here
    if (!lfsr_pkg::lfsr_width_ok(WIDTH)) begin : g_width_check
        $fatal(1, "galois_lfsr: unsupported WIDTH %0d", WIDTH);
    end

    lfsr_seq_ctrl #(
        .WIDTH(WIDTH)
    ) i_seq_ctrl (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .load_evt  (load_evt),
        .seed_data (seed_data),
        .state     (state),
        .op        (op),
        .lfsr_vld  (lfsr_vld),
        .lfsr_done (lfsr_done)
    );

    lfsr_shift_reg #(
        .WIDTH(WIDTH)
    ) i_shift_reg (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .seed_data (seed_data),
        .state     (state)
    );

    assign lfsr_data = state;

endmodule

//--- verilog/lfsr_shift_reg.sv
module lfsr_shift_reg #(
    parameter int WIDTH = lfsr_pkg::LFSR_DEFAULT_WIDTH
) (
    input  logic               clk,
    input  logic               rst,
    input  lfsr_pkg::lfsr_op_e op,
    input  logic [WIDTH-1:0]   seed_data,
    output logic [WIDTH-1:0]   state
);

    localparam logic [WIDTH-1:0] TAPS = WIDTH'(lfsr_pkg::lfsr_tap_mask(WIDTH));
    localparam logic [WIDTH-1:0] SEED = WIDTH'(lfsr_pkg::LFSR_DEFAULT_SEED);

    logic             feedback;
    logic [WIDTH-1:0] step_next;

    // ==========================================================
    // Galois next state
    // ==========================================================
    assign feedback = state[WIDTH-1];

    // Shift up, top bit wraps to bit 0 and hits the taps
    always_comb begin
        step_next[0] = feedback ^ (TAPS[0] & feedback);
        for (int i = 1; i < WIDTH; i++) begin
            step_next[i] = state[i-1] ^ (TAPS[i] & feedback);
        end
    end

    // ==========================================================
    // State register
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SEED;
        end else begin
            case (op)
                lfsr_pkg::LFSR_LOAD_SEED: begin
                    state <= seed_data;
                end
                lfsr_pkg::LFSR_LOAD_DEFAULT: begin
                    state <= SEED;
                end
                lfsr_pkg::LFSR_STEP: begin
                    state <= step_next;
                end
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

//--- verilog/lfsr_seq_ctrl.sv
module lfsr_seq_ctrl #(
    parameter int WIDTH = lfsr_pkg::LFSR_DEFAULT_WIDTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               enable,
    input  logic               load_evt,
    input  logic [WIDTH-1:0]   seed_data,
    input  logic [WIDTH-1:0]   state,
    output lfsr_pkg::lfsr_op_e op,
    output logic               lfsr_vld,
    output logic               lfsr_done
);

    logic [WIDTH-1:0] seed_latch;
    logic             load_flag;
    logic             auto_load;

    // ==========================================================
    // Step command
    // ==========================================================

    // Default seed goes in once, on the first enabled cycle
    assign auto_load = !lfsr_vld && !load_flag;

    always_comb begin
        if (!enable) begin
            op = lfsr_pkg::LFSR_HOLD;
        end else if (load_evt) begin
            op = lfsr_pkg::LFSR_LOAD_SEED;
        end else if (auto_load) begin
            op = lfsr_pkg::LFSR_LOAD_DEFAULT;
        end else begin
            op = lfsr_pkg::LFSR_STEP;
        end
    end

    // ==========================================================
    // Flags and seed latch
    // ==========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seed_latch <= WIDTH'(lfsr_pkg::LFSR_DEFAULT_SEED);
            load_flag  <= 1'b0;
        end else begin
            case (op)
                lfsr_pkg::LFSR_LOAD_SEED: begin
                    seed_latch <= seed_data;
                    load_flag  <= 1'b1;
                end
                lfsr_pkg::LFSR_LOAD_DEFAULT: begin
                    seed_latch <= WIDTH'(lfsr_pkg::LFSR_DEFAULT_SEED);
                    load_flag  <= 1'b1;
                end
                default: begin
                    seed_latch <= seed_latch;
                    load_flag  <= load_flag;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr_vld <= 1'b0;
        end else begin
            lfsr_vld <= enable;
        end
    end

    // Back at the seed, one full period
    assign lfsr_done = lfsr_vld && (state == seed_latch);

endmodule

//--- verilog/lfsr_pkg.sv
package lfsr_pkg;

    // ==========================================================
    // Width limits and defaults
    // ==========================================================
    localparam int LFSR_MIN_WIDTH     = 3;
    localparam int LFSR_MAX_WIDTH     = 168;
    localparam int LFSR_DEFAULT_WIDTH = 8;

    // Only bit 0 set
    localparam int LFSR_DEFAULT_SEED  = 1;

    // Step command from controller to shift register
    typedef enum logic [1:0] {
        LFSR_HOLD         = 2'b00,
        LFSR_LOAD_SEED    = 2'b01,
        LFSR_LOAD_DEFAULT = 2'b10,
        LFSR_STEP         = 2'b11
    } lfsr_op_e;

    // ==========================================================
    // Tap masks
    // ==========================================================

    // Up to three set bits, a negative index is skipped
    function automatic logic [LFSR_MAX_WIDTH-1:0] lfsr_taps(
        input int a,
        input int b = -1,
        input int c = -1
    );
        logic [LFSR_MAX_WIDTH-1:0] m;
        m = '0;
        m[a] = 1'b1;
        if (b >= 0) begin
            m[b] = 1'b1;
        end
        if (c >= 0) begin
            m[c] = 1'b1;
        end
        return m;
    endfunction

    // Bit d set means the outgoing top bit is XORed into new bit d
    function automatic logic [LFSR_MAX_WIDTH-1:0] lfsr_tap_mask(input int width);
        logic [LFSR_MAX_WIDTH-1:0] m;
        case (width)
            3:   m = lfsr_taps(2);
            4:   m = lfsr_taps(3);
            5:   m = lfsr_taps(3);
            6:   m = lfsr_taps(5);
            7:   m = lfsr_taps(6);
            8:   m = lfsr_taps(6, 5, 4);
            9:   m = lfsr_taps(5);
            10:  m = lfsr_taps(7);
            11:  m = lfsr_taps(9);
            12:  m = lfsr_taps(6, 4, 1);
            13:  m = lfsr_taps(4, 3, 1);
            14:  m = lfsr_taps(5, 3, 1);
            15:  m = lfsr_taps(14);
            16:  m = lfsr_taps(15, 13, 4);
            17:  m = lfsr_taps(14);
            18:  m = lfsr_taps(11);
            19:  m = lfsr_taps(6, 2, 1);
            20:  m = lfsr_taps(17);
            21:  m = lfsr_taps(19);
            22:  m = lfsr_taps(21);
            23:  m = lfsr_taps(18);
            24:  m = lfsr_taps(23, 22, 17);
            25:  m = lfsr_taps(22);
            26:  m = lfsr_taps(6, 2, 1);
            27:  m = lfsr_taps(5, 2, 1);
            28:  m = lfsr_taps(25);
            29:  m = lfsr_taps(27);
            30:  m = lfsr_taps(6, 4, 1);
            31:  m = lfsr_taps(28);
            32:  m = lfsr_taps(22, 2, 1);
            33:  m = lfsr_taps(20);
            34:  m = lfsr_taps(27, 2, 1);
            35:  m = lfsr_taps(33);
            36:  m = lfsr_taps(25);
            37:  m = lfsr_taps(5, 4, 3) | lfsr_taps(2, 1);
            38:  m = lfsr_taps(6, 5, 1);
            39:  m = lfsr_taps(35);
            40:  m = lfsr_taps(38, 21, 19);
            41:  m = lfsr_taps(38);
            42:  m = lfsr_taps(41, 20, 19);
            43:  m = lfsr_taps(42, 38, 37);
            44:  m = lfsr_taps(43, 18, 17);
            45:  m = lfsr_taps(44, 42, 41);
            46:  m = lfsr_taps(45, 26, 25);
            47:  m = lfsr_taps(42);
            48:  m = lfsr_taps(47, 21, 20);
            49:  m = lfsr_taps(40);
            50:  m = lfsr_taps(49, 24, 23);
            51:  m = lfsr_taps(50, 36, 35);
            52:  m = lfsr_taps(49);
            53:  m = lfsr_taps(52, 38, 37);
            54:  m = lfsr_taps(53, 18, 17);
            55:  m = lfsr_taps(31);
            56:  m = lfsr_taps(55, 35, 34);
            57:  m = lfsr_taps(50);
            58:  m = lfsr_taps(39);
            59:  m = lfsr_taps(58, 38, 37);
            60:  m = lfsr_taps(59);
            61:  m = lfsr_taps(60, 46, 45);
            62:  m = lfsr_taps(61, 6, 5);
            63:  m = lfsr_taps(62);
            64:  m = lfsr_taps(63, 61, 60);
            65:  m = lfsr_taps(47);
            66:  m = lfsr_taps(65, 57, 56);
            67:  m = lfsr_taps(66, 58, 57);
            68:  m = lfsr_taps(59);
            69:  m = lfsr_taps(67, 42, 40);
            70:  m = lfsr_taps(69, 55, 54);
            // Polynomial x^71 + x^65 + 1, the table had no entry here
            71:  m = lfsr_taps(65);
            72:  m = lfsr_taps(66, 25, 19);
            73:  m = lfsr_taps(48);
            74:  m = lfsr_taps(73, 59, 58);
            75:  m = lfsr_taps(74, 65, 64);
            76:  m = lfsr_taps(75, 41, 40);
            77:  m = lfsr_taps(76, 47, 46);
            78:  m = lfsr_taps(77, 59, 58);
            79:  m = lfsr_taps(70);
            80:  m = lfsr_taps(79, 43, 42);
            81:  m = lfsr_taps(77);
            82:  m = lfsr_taps(79, 47, 44);
            83:  m = lfsr_taps(82, 38, 37);
            84:  m = lfsr_taps(71);
            85:  m = lfsr_taps(84, 58, 57);
            86:  m = lfsr_taps(85, 74, 73);
            87:  m = lfsr_taps(74);
            88:  m = lfsr_taps(87, 17, 16);
            89:  m = lfsr_taps(51);
            90:  m = lfsr_taps(89, 72, 71);
            91:  m = lfsr_taps(90, 8, 7);
            92:  m = lfsr_taps(91, 80, 79);
            93:  m = lfsr_taps(91);
            94:  m = lfsr_taps(73);
            95:  m = lfsr_taps(84);
            96:  m = lfsr_taps(94, 49, 47);
            97:  m = lfsr_taps(91);
            98:  m = lfsr_taps(87);
            99:  m = lfsr_taps(97, 54, 52);
            100: m = lfsr_taps(63);
            101: m = lfsr_taps(100, 95, 94);
            102: m = lfsr_taps(101, 36, 35);
            103: m = lfsr_taps(94);
            104: m = lfsr_taps(103, 94, 93);
            105: m = lfsr_taps(89);
            106: m = lfsr_taps(91);
            107: m = lfsr_taps(105, 44, 42);
            108: m = lfsr_taps(77);
            109: m = lfsr_taps(108, 103, 102);
            110: m = lfsr_taps(109, 98, 97);
            111: m = lfsr_taps(101);
            112: m = lfsr_taps(110, 69, 67);
            113: m = lfsr_taps(104);
            114: m = lfsr_taps(113, 33, 32);
            115: m = lfsr_taps(114, 101, 100);
            116: m = lfsr_taps(115, 46, 45);
            117: m = lfsr_taps(115, 99, 97);
            118: m = lfsr_taps(85);
            119: m = lfsr_taps(111);
            120: m = lfsr_taps(113, 9, 2);
            121: m = lfsr_taps(103);
            122: m = lfsr_taps(121, 63, 62);
            123: m = lfsr_taps(121);
            124: m = lfsr_taps(87);
            125: m = lfsr_taps(124, 18, 17);
            126: m = lfsr_taps(125, 90, 89);
            127: m = lfsr_taps(126);
            128: m = lfsr_taps(126, 101, 99);
            129: m = lfsr_taps(124);
            130: m = lfsr_taps(127);
            131: m = lfsr_taps(130, 84, 83);
            132: m = lfsr_taps(103);
            133: m = lfsr_taps(132, 82, 81);
            134: m = lfsr_taps(77);
            135: m = lfsr_taps(124);
            136: m = lfsr_taps(135, 11, 10);
            137: m = lfsr_taps(116);
            138: m = lfsr_taps(137, 131, 130);
            139: m = lfsr_taps(136, 134, 131);
            140: m = lfsr_taps(111);
            141: m = lfsr_taps(140, 110, 109);
            142: m = lfsr_taps(121);
            143: m = lfsr_taps(142, 123, 122);
            144: m = lfsr_taps(143, 75, 74);
            145: m = lfsr_taps(93);
            146: m = lfsr_taps(145, 87, 86);
            147: m = lfsr_taps(146, 110, 109);
            148: m = lfsr_taps(121);
            149: m = lfsr_taps(148, 40, 39);
            150: m = lfsr_taps(97);
            151: m = lfsr_taps(148);
            152: m = lfsr_taps(151, 87, 86);
            153: m = lfsr_taps(152);
            154: m = lfsr_taps(152, 27, 25);
            155: m = lfsr_taps(154, 124, 123);
            156: m = lfsr_taps(155, 41, 40);
            157: m = lfsr_taps(156, 131, 130);
            158: m = lfsr_taps(157, 132, 131);
            159: m = lfsr_taps(128);
            160: m = lfsr_taps(159, 142, 141);
            161: m = lfsr_taps(143);
            162: m = lfsr_taps(161, 75, 74);
            163: m = lfsr_taps(162, 104, 103);
            164: m = lfsr_taps(163, 151, 150);
            165: m = lfsr_taps(164, 135, 134);
            166: m = lfsr_taps(165, 128, 127);
            167: m = lfsr_taps(161);
            168: m = lfsr_taps(166, 153, 151);
            default: m = '0;
        endcase
        return m;
    endfunction

    function automatic bit lfsr_width_ok(input int width);
        return (width >= LFSR_MIN_WIDTH) && (width <= LFSR_MAX_WIDTH) &&
               (lfsr_tap_mask(width) != '0);
    endfunction

endpackage
